// File: qla_axis_ctrl.f
hw/qla_pkg.sv
hw/axil_reg_port.sv
hw/dac_cmd_regs.sv
hw/adc_feedback.sv
hw/safety_monitor.sv
hw/qla_axis_ctrl.sv
test/qla_axis_ctrl_sva.sv
test/qla_axis_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and judge the run from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f qla_axis_ctrl.f --top-module qla_axis_ctrl_tb \
    --Mdir obj_dir -o qla_axis_ctrl_sim > sim.log 2>&1 \
    && ./obj_dir/qla_axis_ctrl_sim >> sim.log 2>&1 \
    || { cat sim.log; echo "FAIL: build or simulation aborted"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"

// File: test/qla_axis_ctrl_tb.sv
module qla_axis_ctrl_tb;

    localparam int wait_limit = 32;             // cycles before a wait gives up

    typedef enum logic [1:0] {step_write, step_read, step_adc} step_kind_t;

    typedef struct {
        step_kind_t          kind;
        string               name;
        qla_pkg::addr_t      addr;
        qla_pkg::data_t      wdata;
        qla_pkg::data_t      exp_data;          // read steps only
        qla_pkg::cur_vec_t   samples;           // adc steps only
        qla_pkg::cur_vec_t   exp_cmd;           // dac_cmd after the step
        qla_pkg::axis_mask_t exp_mask;          // amp_disable after the step
    } step_t;

    logic                sysclk;
    logic                reset;
    qla_pkg::addr_t      s_axil_awaddr;
    qla_pkg::addr_t      s_axil_araddr;
    qla_pkg::data_t      s_axil_wdata;
    qla_pkg::data_t      s_axil_rdata;
    logic                s_axil_awvalid;
    logic                s_axil_wvalid;
    logic                s_axil_bready;
    logic                s_axil_arvalid;
    logic                s_axil_rready;
    logic                s_axil_awready;
    logic                s_axil_wready;
    logic                s_axil_bvalid;
    logic                s_axil_arready;
    logic                s_axil_rvalid;
    logic [1:0]          s_axil_bresp;
    logic [1:0]          s_axil_rresp;
    qla_pkg::adc_in_t    adc_in;
    qla_pkg::cur_vec_t   dac_cmd;
    qla_pkg::axis_mask_t amp_disable;

    step_t               steps [64];
    int                  n_steps;
    int                  value_errors;
    int                  timeout_errors;
    qla_pkg::cur_vec_t   cmd_exp;               // model state while the table is built
    qla_pkg::cur_vec_t   fb_exp;
    qla_pkg::axis_mask_t mask_exp;

    qla_axis_ctrl DUT (
        .sysclk         (sysclk),
        .reset          (reset),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .adc_in         (adc_in),
        .dac_cmd        (dac_cmd),
        .amp_disable    (amp_disable)
    );

    always #50 sysclk = ~sysclk;                // period 100

    // --------------------------------------------------
    // one compare task per result type
    // --------------------------------------------------

    task automatic check_data(input string name, input qla_pkg::data_t exp,
                              input qla_pkg::data_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_cur_vec(input string name, input qla_pkg::cur_vec_t exp,
                                 input qla_pkg::cur_vec_t act);
        if (act !== exp) begin
            $display("** Error %s: expected dac_cmd %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_mask(input string name, input qla_pkg::axis_mask_t exp,
                              input qla_pkg::axis_mask_t act);
        if (act !== exp) begin
            $display("** Error %s: expected amp_disable %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    // --------------------------------------------------
    // bus and adc drivers
    // --------------------------------------------------

    // returns at a falling edge with the write in effect
    task automatic axil_write(input qla_pkg::addr_t addr, input qla_pkg::data_t data,
                              output logic [1:0] resp);
        int t;
        @(posedge sysclk);
        s_axil_awaddr <= addr;
        s_axil_awvalid <= 1'b1;
        s_axil_wdata <= data;
        s_axil_wvalid <= 1'b1;
        t = 0;
        do begin
            @(negedge sysclk);
            t++;
        end while (!(s_axil_awready && s_axil_wready) && t < wait_limit);
        if (!(s_axil_awready && s_axil_wready)) begin
            $display("timeout: write to address %h was never accepted", addr);
            timeout_errors++;
        end
        @(posedge sysclk);                      // accepted on this edge
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid <= 1'b0;
        t = 0;
        do begin
            @(negedge sysclk);
            t++;
        end while (!s_axil_bvalid && t < wait_limit);
        if (!s_axil_bvalid) begin
            $display("timeout: no write response for address %h", addr);
            timeout_errors++;
        end
        resp = s_axil_bresp;
        @(posedge sysclk);                      // registers load, bready still low
        s_axil_bready <= 1'b1;
        @(posedge sysclk);                      // response taken
        s_axil_bready <= 1'b0;
        @(negedge sysclk);
    endtask

    task automatic axil_read(input qla_pkg::addr_t addr, output qla_pkg::data_t data,
                             output logic [1:0] resp);
        int t;
        @(posedge sysclk);
        s_axil_araddr <= addr;
        s_axil_arvalid <= 1'b1;
        t = 0;
        do begin
            @(negedge sysclk);
            t++;
        end while (!s_axil_arready && t < wait_limit);
        if (!s_axil_arready) begin
            $display("timeout: read of address %h was never accepted", addr);
            timeout_errors++;
        end
        @(posedge sysclk);
        s_axil_arvalid <= 1'b0;
        t = 0;
        do begin
            @(negedge sysclk);
            t++;
        end while (!s_axil_rvalid && t < wait_limit);
        if (!s_axil_rvalid) begin
            $display("timeout: no read data for address %h", addr);
            timeout_errors++;
        end
        @(posedge sysclk);                      // one stalled cycle, rvalid must hold
        s_axil_rready <= 1'b1;
        @(negedge sysclk);
        data = s_axil_rdata;                    // taken on the next edge
        resp = s_axil_rresp;
        @(posedge sysclk);
        s_axil_rready <= 1'b0;
        @(negedge sysclk);
    endtask

    // fixed pipeline of capture then one cycle for the monitor
    task automatic adc_sample(input qla_pkg::cur_vec_t s);
        @(posedge sysclk);
        adc_in <= '{valid: 1'b1, samples: s};
        @(posedge sysclk);
        adc_in.valid <= 1'b0;                   // fb loads on this edge
        @(posedge sysclk);                      // counters and mask update
        @(negedge sysclk);
    endtask

    // --------------------------------------------------
    // step table
    // --------------------------------------------------

    function automatic qla_pkg::addr_t reg_addr(input int chan, input int off);
        return qla_pkg::addr_t'(chan * 16 + off);
    endfunction

    // over-limit axes get 2 * cmd + 256 + extra and the rest sit at their command
    function automatic qla_pkg::cur_vec_t make_samples(input qla_pkg::axis_mask_t hi,
                                                       input int extra);
        qla_pkg::cur_vec_t s;
        for (int i = 0; i < qla_pkg::num_axes; i++) begin
            if (hi[i]) begin
                s[i] = qla_pkg::cur_t'(2 * int'(cmd_exp[i]) + 256 + extra);
            end else begin
                s[i] = cmd_exp[i];
            end
        end
        return s;
    endfunction

    task automatic add_step(input step_kind_t kind, input string name,
                            input qla_pkg::addr_t addr, input qla_pkg::data_t wdata,
                            input qla_pkg::data_t exp_data);
        steps[n_steps].kind = kind;
        steps[n_steps].name = name;
        steps[n_steps].addr = addr;
        steps[n_steps].wdata = wdata;
        steps[n_steps].exp_data = exp_data;
        steps[n_steps].samples = fb_exp;
        steps[n_steps].exp_cmd = cmd_exp;
        steps[n_steps].exp_mask = mask_exp;
        n_steps++;
    endtask

    task automatic build_table();
        qla_pkg::cur_t c;
        cmd_exp = '0;
        fb_exp = '0;
        mask_exp = '0;
        // everything reads zero out of reset
        for (int a = 1; a <= qla_pkg::num_axes; a++) begin
            for (int o = 0; o < 2; o++) begin
                add_step(step_read, $sformatf("axis %0d offset %0d after reset", a, o),
                         reg_addr(a, o), '0, '0);
            end
        end
        add_step(step_read, "amp_status after reset", reg_addr(0, 0), '0, '0);
        // random commands with junk in the upper half of the word
        for (int a = 1; a <= qla_pkg::num_axes; a++) begin
            c = qla_pkg::cur_t'($urandom_range(4000, 100));
            cmd_exp[a-1] = c;
            add_step(step_write, $sformatf("axis %0d dac_ctrl write", a), reg_addr(a, 1),
                     {qla_pkg::cur_t'($urandom), c}, '0);
            add_step(step_read, $sformatf("axis %0d dac_ctrl readback", a), reg_addr(a, 1),
                     '0, {16'h0000, c});
        end
        fb_exp = make_samples('0, 0);
        add_step(step_adc, "adc set in limit", '0, '0, '0);
        for (int a = 1; a <= qla_pkg::num_axes; a++) begin
            add_step(step_read, $sformatf("axis %0d adc_data", a), reg_addr(a, 0), '0,
                     {cmd_exp[a-1], fb_exp[a-1]});
        end
        // axis 2 over three times then a sample exactly at the limit restarts the run
        fb_exp = make_samples(4'b0010, 1);
        for (int k = 0; k < 3; k++) begin
            add_step(step_adc, "axis 2 over, first run", '0, '0, '0);
        end
        fb_exp = make_samples(4'b0010, 0);
        add_step(step_adc, "axis 2 at limit", '0, '0, '0);
        fb_exp = make_samples(4'b0010, 1);
        for (int k = 0; k < 3; k++) begin
            add_step(step_adc, "axis 2 over, second run", '0, '0, '0);
        end
        mask_exp = 4'b0010;
        add_step(step_adc, "axis 2 fourth over trips", '0, '0, '0);
        add_step(step_read, "amp_status axis 2 tripped", reg_addr(0, 0), '0, 32'h2);
        add_step(step_read, "axis 2 adc_data over", reg_addr(2, 0), '0, {cmd_exp[1], fb_exp[1]});
        // axis 4 trips too so the clear has a bystander
        fb_exp = make_samples(4'b1000, 1);
        for (int k = 0; k < 3; k++) begin
            add_step(step_adc, "axis 4 over", '0, '0, '0);
        end
        mask_exp = 4'b1010;
        add_step(step_adc, "axis 4 fourth over trips", '0, '0, '0);
        mask_exp = 4'b1000;
        add_step(step_write, "amp_clear axis 2", reg_addr(0, 1), 32'h2, '0);
        add_step(step_read, "amp_status after clear", reg_addr(0, 0), '0, 32'h8);
        // holes in the register map
        add_step(step_read, "unmapped axis offset", reg_addr(1, 7), '0, '0);
        add_step(step_read, "unmapped board offset", reg_addr(0, 2), '0, '0);
        add_step(step_read, "unmapped channel", reg_addr(6, 0), '0, '0);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------

    initial begin
        qla_pkg::data_t rdata;
        logic [1:0]     resp;
        void'($urandom(32'hc9bd8279));
        sysclk = 1'b0;
        reset = 1'b1;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        adc_in = '0;
        n_steps = 0;
        value_errors = 0;
        timeout_errors = 0;
        build_table();
        repeat (4) @(posedge sysclk);
        reset <= 1'b0;
        for (int k = 0; k < n_steps; k++) begin
            case (steps[k].kind)
                step_write: begin
                    axil_write(steps[k].addr, steps[k].wdata, resp);
                    check_data({steps[k].name, " bresp"}, 32'h0, qla_pkg::data_t'(resp));
                end
                step_read: begin
                    axil_read(steps[k].addr, rdata, resp);
                    check_data(steps[k].name, steps[k].exp_data, rdata);
                    check_data({steps[k].name, " rresp"}, 32'h0, qla_pkg::data_t'(resp));
                end
                default: adc_sample(steps[k].samples);
            endcase
            check_cur_vec(steps[k].name, steps[k].exp_cmd, dac_cmd);
            check_mask(steps[k].name, steps[k].exp_mask, amp_disable);
        end
        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: test/qla_axis_ctrl_sva.sv
module qla_axis_ctrl_sva (
    input logic                sysclk,
    input logic                reset,
    input logic                s_axil_bvalid,
    input logic                s_axil_bready,
    input logic [1:0]          s_axil_bresp,
    input logic                s_axil_rvalid,
    input logic                s_axil_rready,
    input logic [1:0]          s_axil_rresp,
    input qla_pkg::axis_mask_t amp_disable
);

    // --------------------------------------------------
    // response channels
    // --------------------------------------------------

    bvalid_hold: assert property (@(posedge sysclk) disable iff (reset)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge sysclk) disable iff (reset)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
        else $error("rvalid dropped before rready");

    bresp_okay: assert property (@(posedge sysclk) disable iff (reset)
        s_axil_bvalid |-> s_axil_bresp == qla_pkg::resp_okay)
        else $error("bresp not OKAY");

    rresp_okay: assert property (@(posedge sysclk) disable iff (reset)
        s_axil_rvalid |-> s_axil_rresp == qla_pkg::resp_okay)
        else $error("rresp not OKAY");

    // amplifiers come up enabled
    amp_after_reset: assert property (@(posedge sysclk)
        reset |=> amp_disable == '0)
        else $error("amp_disable set after reset");

endmodule

bind qla_axis_ctrl qla_axis_ctrl_sva u_sva (
    .sysclk        (sysclk),
    .reset         (reset),
    .s_axil_bvalid (s_axil_bvalid),
    .s_axil_bready (s_axil_bready),
    .s_axil_bresp  (s_axil_bresp),
    .s_axil_rvalid (s_axil_rvalid),
    .s_axil_rready (s_axil_rready),
    .s_axil_rresp  (s_axil_rresp),
    .amp_disable   (amp_disable)
);

// File: hw/qla_axis_ctrl.sv
module qla_axis_ctrl (
    input  logic                sysclk,
    input  logic                reset,

    // axi4-lite slave
    input  qla_pkg::addr_t      s_axil_awaddr,
    input  logic                s_axil_awvalid,
    output logic                s_axil_awready,
    input  qla_pkg::data_t      s_axil_wdata,
    input  logic                s_axil_wvalid,
    output logic                s_axil_wready,
    output logic [1:0]          s_axil_bresp,
    output logic                s_axil_bvalid,
    input  logic                s_axil_bready,
    input  qla_pkg::addr_t      s_axil_araddr,
    input  logic                s_axil_arvalid,
    output logic                s_axil_arready,
    output qla_pkg::data_t      s_axil_rdata,
    output logic [1:0]          s_axil_rresp,
    output logic                s_axil_rvalid,
    input  logic                s_axil_rready,

    // analog side
    input  qla_pkg::adc_in_t    adc_in,         // current feedback samples
    output qla_pkg::cur_vec_t   dac_cmd,        // current commands
    output qla_pkg::axis_mask_t amp_disable     // to the amplifier enables
);

    qla_pkg::reg_wr_t  reg_wr;                  // shared write strobe
    qla_pkg::cur_vec_t cmd;
    qla_pkg::cur_vec_t fb;
    logic              fb_strobe;
    qla_pkg::rd_state_t rd_state;

    // --------------------------------------------------
    // bus port
    // --------------------------------------------------

    assign rd_state = '{cmd: cmd, fb: fb, amp_disable: amp_disable};

    axil_reg_port u_port (
        .sysclk         (sysclk),
        .reset          (reset),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .rd_state       (rd_state),
        .reg_wr         (reg_wr)
    );

    // --------------------------------------------------
    // dac commands and adc feedback
    // --------------------------------------------------

    dac_cmd_regs u_dac (
        .sysclk (sysclk),
        .reset  (reset),
        .reg_wr (reg_wr),
        .cmd    (cmd)
    );

    assign dac_cmd = cmd;                       // parallel words to the dacs

    adc_feedback u_adc (
        .sysclk    (sysclk),
        .reset     (reset),
        .adc_in    (adc_in),
        .fb        (fb),
        .fb_strobe (fb_strobe)
    );

    // --------------------------------------------------
    // safety check of fb against 2 * cmd per axis
    // --------------------------------------------------

    safety_monitor u_safety (
        .sysclk      (sysclk),
        .reset       (reset),
        .cmd         (cmd),
        .fb          (fb),
        .fb_strobe   (fb_strobe),
        .reg_wr      (reg_wr),
        .amp_disable (amp_disable)
    );

endmodule

// File: hw/safety_monitor.sv
module safety_monitor (
    input  logic                sysclk,
    input  logic                reset,
    input  qla_pkg::cur_vec_t   cmd,            // commanded current
    input  qla_pkg::cur_vec_t   fb,             // measured current
    input  logic                fb_strobe,      // new feedback set
    input  qla_pkg::reg_wr_t    reg_wr,         // for the clear register
    output qla_pkg::axis_mask_t amp_disable     // latched per-axis disable
);

    logic [17:0]          limit [qla_pkg::num_axes];   // 2 * cmd + margin
    qla_pkg::axis_mask_t  over;                 // feedback above limit
    qla_pkg::trip_cnt_t   trip_cnt [qla_pkg::num_axes];
    logic                 amp_clear;            // write to off_amp_clear
    qla_pkg::axis_mask_t  clr_mask;

    // --------------------------------------------------
    // limit compare
    // --------------------------------------------------

    // 18 bits so 2 * 16'hffff + margin cannot wrap
    always_comb begin
        for (int i = 0; i < qla_pkg::num_axes; i++) begin
            limit[i] = {1'b0, cmd[i], 1'b0} + 18'(qla_pkg::safety_margin);
            over[i] = {2'b00, fb[i]} > limit[i];
        end
    end

    // clear lives on the board channel
    assign amp_clear = reg_wr.wen
                    && (qla_pkg::addr_chan(reg_wr.waddr) == qla_pkg::chan_board)
                    && (qla_pkg::addr_off(reg_wr.waddr) == qla_pkg::off_amp_clear);
    assign clr_mask = reg_wr.wdata[qla_pkg::num_axes-1:0];

    // --------------------------------------------------
    // trip counters and disable latch
    // --------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (reset) begin
            amp_disable <= '0;
            for (int i = 0; i < qla_pkg::num_axes; i++) begin
                trip_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < qla_pkg::num_axes; i++) begin
                if (amp_clear && clr_mask[i]) begin
                    // clear wins over a same-cycle sample
                    trip_cnt[i] <= '0;
                    amp_disable[i] <= 1'b0;
                end else if (fb_strobe) begin
                    if (!over[i]) begin
                        trip_cnt[i] <= '0;      // run broken so start over
                    end else if (trip_cnt[i] != qla_pkg::safety_count) begin
                        trip_cnt[i] <= trip_cnt[i] + qla_pkg::trip_cnt_t'(1);
                        if (trip_cnt[i] == qla_pkg::safety_count - qla_pkg::trip_cnt_t'(1)) begin
                            amp_disable[i] <= 1'b1;   // trip
                        end
                    end
                    // saturated counter just holds
                end
            end
        end
    end

endmodule

// File: hw/adc_feedback.sv
module adc_feedback (
    input  logic              sysclk,
    input  logic              reset,
    input  qla_pkg::adc_in_t  adc_in,           // parallel samples + valid
    output qla_pkg::cur_vec_t fb,               // last captured feedback
    output logic              fb_strobe         // one pulse per conversion
);

    // --------------------------------------------------
    // sample capture
    // --------------------------------------------------

    // all four currents convert together, so one strobe covers them
    always_ff @(posedge sysclk) begin
        if (reset) begin
            fb <= '0;
        end else if (adc_in.valid) begin
            fb <= adc_in.samples;               // hold until next conversion
        end
    end

    // strobe lines up with the updated fb
    always_ff @(posedge sysclk) begin
        if (reset) begin
            fb_strobe <= 1'b0;
        end else begin
            fb_strobe <= adc_in.valid;
        end
    end

    // no back-pressure toward the adc
    // a conversion during a bus stall still lands here

endmodule

// File: hw/dac_cmd_regs.sv
module dac_cmd_regs (
    input  logic              sysclk,
    input  logic              reset,
    input  qla_pkg::reg_wr_t  reg_wr,           // from bus port
    output qla_pkg::cur_vec_t cmd               // current commands to the dacs
);

    qla_pkg::chan_t wr_chan;                    // target channel of the write
    qla_pkg::off_t  wr_off;
    logic           dac_wr;                     // write hits a dac_ctrl offset
    qla_pkg::cur_t  new_cmd;

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------

    assign wr_chan = qla_pkg::addr_chan(reg_wr.waddr);
    assign wr_off = qla_pkg::addr_off(reg_wr.waddr);
    assign dac_wr = reg_wr.wen && (wr_off == qla_pkg::off_dac_ctrl);

    // only the low half of the bus word carries the command
    assign new_cmd = reg_wr.wdata[15:0];

    // --------------------------------------------------
    // command registers
    // --------------------------------------------------

    // one register per axis with channel i+1 loading slot i
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cmd <= '0;                          // amplifiers start at zero current
        end else if (dac_wr) begin
            for (int i = 0; i < qla_pkg::num_axes; i++) begin
                if (wr_chan == qla_pkg::chan_t'(i + 1)) begin
                    cmd[i] <= new_cmd;
                end
            end
        end
    end

    // board channel and unused channels fall through untouched
    // dac serial shift-out happens outside this block

endmodule

// File: hw/axil_reg_port.sv
module axil_reg_port (
    input  logic               sysclk,
    input  logic               reset,

    // write address and data
    input  qla_pkg::addr_t     s_axil_awaddr,
    input  logic               s_axil_awvalid,
    output logic               s_axil_awready,
    input  qla_pkg::data_t     s_axil_wdata,
    input  logic               s_axil_wvalid,
    output logic               s_axil_wready,

    // write response
    output logic [1:0]         s_axil_bresp,
    output logic               s_axil_bvalid,
    input  logic               s_axil_bready,

    // read address and data
    input  qla_pkg::addr_t     s_axil_araddr,
    input  logic               s_axil_arvalid,
    output logic               s_axil_arready,
    output qla_pkg::data_t     s_axil_rdata,
    output logic [1:0]         s_axil_rresp,
    output logic               s_axil_rvalid,
    input  logic               s_axil_rready,

    // register side
    input  qla_pkg::rd_state_t rd_state,        // readable state of the board
    output qla_pkg::reg_wr_t   reg_wr           // write strobe to the banks
);

    logic                wr_accept;             // aw and w taken together
    logic                rd_accept;
    logic                wen_q;
    qla_pkg::addr_t      waddr_q;
    qla_pkg::data_t      wdata_q;
    qla_pkg::chan_t      rd_chan;
    qla_pkg::off_t       rd_off;
    qla_pkg::axis_idx_t  rd_axis;
    qla_pkg::data_t      rd_word;               // selected read word

    // --------------------------------------------------
    // write channel
    // --------------------------------------------------

    // both halves must be present and at most one write in flight
    assign wr_accept = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_accept;
    assign s_axil_wready = wr_accept;
    assign s_axil_bresp = qla_pkg::resp_okay;   // no slave errors

    always_ff @(posedge sysclk) begin
        if (reset) begin
            wen_q <= 1'b0;
            s_axil_bvalid <= 1'b0;
        end else begin
            wen_q <= wr_accept;                 // single pulse since bvalid blocks a repeat
            if (wr_accept) begin
                s_axil_bvalid <= 1'b1;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;          // response taken
            end
        end
    end

    // holding register for the accepted write
    always_ff @(posedge sysclk) begin
        if (wr_accept) begin
            waddr_q <= s_axil_awaddr;
            wdata_q <= s_axil_wdata;
        end
    end

    assign reg_wr = '{wen: wen_q, waddr: waddr_q, wdata: wdata_q};

    // --------------------------------------------------
    // read channel
    // --------------------------------------------------

    assign rd_accept = s_axil_arvalid && !s_axil_rvalid;
    assign s_axil_arready = rd_accept;
    assign s_axil_rresp = qla_pkg::resp_okay;

    assign rd_chan = qla_pkg::addr_chan(s_axil_araddr);
    assign rd_off = qla_pkg::addr_off(s_axil_araddr);
    assign rd_axis = qla_pkg::chan_axis(rd_chan);

    // read mux where anything unmapped returns zero
    always_comb begin
        rd_word = '0;
        if (rd_chan == qla_pkg::chan_board) begin
            if (rd_off == qla_pkg::off_amp_status) begin
                rd_word = qla_pkg::data_t'(rd_state.amp_disable);
            end
        end else if (rd_chan <= qla_pkg::chan_t'(qla_pkg::num_axes)) begin
            case (rd_off)
                qla_pkg::off_adc_data: rd_word = {rd_state.cmd[rd_axis], rd_state.fb[rd_axis]};
                qla_pkg::off_dac_ctrl: rd_word = qla_pkg::data_t'(rd_state.cmd[rd_axis]);
                default:               rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            s_axil_rvalid <= 1'b0;
        end else if (rd_accept) begin
            s_axil_rvalid <= 1'b1;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;              // data taken
        end
    end

    always_ff @(posedge sysclk) begin
        if (rd_accept) begin
            s_axil_rdata <= rd_word;            // snapshot at accept
        end
    end

endmodule

// File: hw/qla_pkg.sv
package qla_pkg;

    // --------------------------------------------------
    // sizes and vector types
    // --------------------------------------------------

    localparam int num_axes = 4;                // motor axes on one board

    typedef logic [15:0] addr_t;                // register byte address
    typedef logic [31:0] data_t;                // register data word
    typedef logic [15:0] cur_t;                 // current in dac/adc counts
    typedef cur_t [num_axes-1:0] cur_vec_t;     // slot 0 holds axis 1
    typedef logic [num_axes-1:0] axis_mask_t;   // one bit per axis
    typedef logic [2:0] trip_cnt_t;             // consecutive over-limit samples
    typedef logic [3:0] chan_t;                 // address bits 7..4
    typedef logic [3:0] off_t;                  // address bits 3..0
    typedef logic [$clog2(num_axes)-1:0] axis_idx_t;

    // --------------------------------------------------
    // register map
    // --------------------------------------------------

    localparam chan_t chan_board = 4'd0;        // board-wide registers
    localparam off_t off_adc_data = 4'd0;       // axis reads {cmd, fb}
    localparam off_t off_dac_ctrl = 4'd1;       // axis current command
    localparam off_t off_amp_status = 4'd0;     // board disable mask
    localparam off_t off_amp_clear = 4'd1;      // board write 1 to clear

    // safety check limits
    localparam cur_t safety_margin = 16'd256;   // allowance above 2 * cmd
    localparam trip_cnt_t safety_count = 3'd4;  // samples before trip

    localparam logic [1:0] resp_okay = 2'b00;   // axi OKAY

    // --------------------------------------------------
    // bundles
    // --------------------------------------------------

    typedef struct packed {
        logic  wen;                             // one-cycle write strobe
        addr_t waddr;
        data_t wdata;
    } reg_wr_t;

    typedef struct packed {
        logic     valid;                        // conversion done
        cur_vec_t samples;
    } adc_in_t;

    typedef struct packed {
        cur_vec_t   cmd;
        cur_vec_t   fb;
        axis_mask_t amp_disable;
    } rd_state_t;

    // address field helpers
    function automatic chan_t addr_chan(input addr_t addr);
        return addr[7:4];
    endfunction

    function automatic off_t addr_off(input addr_t addr);
        return addr[3:0];
    endfunction

    // channels 1..num_axes map onto slots 0..num_axes-1
    function automatic axis_idx_t chan_axis(input chan_t chan);
        return axis_idx_t'(chan - chan_t'(1));
    endfunction

endpackage
